// File: hw/shell_pkg.sv
/*
 * Shared types and constants for the BAR1 register path.
 * Register window is 16 bytes. Only the two scratch slots are writable.
 */
`default_nettype none

package shell_pkg;

  // --------------------
  // Bus widths
  // --------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // AXI response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // --------------------
  // Register map
  // --------------------
  // Slot chosen by address bits 3..2
  typedef enum logic [1:0] {
    REG_ID0      = 2'd0,
    REG_ID1      = 2'd1,
    REG_SCRATCH0 = 2'd2,
    REG_SCRATCH1 = 2'd3
  } reg_sel_e;

  // Any address bit at or above this index falls outside the window
  localparam int REG_WINDOW_BITS = 4;

  typedef enum logic {
    WR_IDLE = 1'b0,
    WR_RESP = 1'b1
  } wr_state_e;

  // Identity words readable at 0x0 and 0x4
  localparam data_t DEFAULT_ID0 = 32'hF000_1D0F;
  localparam data_t DEFAULT_ID1 = 32'h1D51_FEDD;

endpackage

`default_nettype wire

// File: hw/axil_if.sv
/*
 * One AXI-Lite bus, no protection or user fields.
 */
`timescale 1ns/1ps
`default_nettype none

interface axil_if;
  import shell_pkg::*;

  // Write address and data
  logic  awvalid;
  logic  awready;
  addr_t awaddr;
  logic  wvalid;
  logic  wready;
  data_t wdata;
  strb_t wstrb;

  // Write response
  logic  bvalid;
  logic  bready;
  resp_e bresp;

  // Read address and data
  logic  arvalid;
  logic  arready;
  addr_t araddr;
  logic  rvalid;
  logic  rready;
  data_t rdata;
  resp_e rresp;

  modport master (
    output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

  modport slave (
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
    output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
  );

endinterface

`default_nettype wire

// File: hw/rst_flr_ctrl.sv
/*
 * Reset stretcher and FLR acknowledge. RST_STAGES must be 2 or more.
 * pipe_rst_n is sampled on clk, so it must already be clean in this domain.
 */
`timescale 1ns/1ps
`default_nettype none

module rst_flr_ctrl #(
  parameter int RST_STAGES = 4
) (
  input  logic clk,
  input  logic pipe_rst_n,
  input  logic flr_assert,
  output logic sync_rst_n,
  output logic flr_done
);

  logic [RST_STAGES-1:0] rst_pipe;
  logic                  flr_assert_q;

  // Ones shift in once the incoming reset is released
  always_ff @(posedge clk)
  begin
    if (!pipe_rst_n)
      rst_pipe <= '0;
    else
      rst_pipe <= {rst_pipe[RST_STAGES-2:0], 1'b1};
  end

  assign sync_rst_n = rst_pipe[RST_STAGES-1];

  // --------------------
  // FLR acknowledge
  // --------------------
  // Held clear from the first reset edge until the bus reset lifts
  always_ff @(posedge clk)
  begin
    if (!pipe_rst_n || !sync_rst_n)
    begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end
    else
    begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_assert_q && !flr_done;
    end
  end

  // Acknowledge is always a single-cycle pulse
  a_flr_done_pulse: assert property (
    @(posedge clk) disable iff (!sync_rst_n) flr_done |=> !flr_done
  );

endmodule

`default_nettype wire

// File: hw/axil_reg_slice.sv
/*
 * Full AXI-Lite register slice, one entry per channel, one cycle per stage.
 * Readies stay low until the cycle after sync_rst_n is released.
 */
`timescale 1ns/1ps
`default_nettype none

module axil_reg_slice (
  input  logic   clk,
  input  logic   sync_rst_n,
  axil_if.slave  s,
  axil_if.master m
);
  import shell_pkg::*;

  // Channel slots; AW, W, AR run forward, B and R run back
  localparam int CH_AW = 0;
  localparam int CH_W  = 1;
  localparam int CH_AR = 2;
  localparam int CH_B  = 3;
  localparam int CH_R  = 4;
  localparam int NCH   = 5;

  // Widest payload is W, data plus strobes
  localparam int PW = $bits(data_t) + $bits(strb_t);

  logic [NCH-1:0] in_valid;
  logic [NCH-1:0] in_ready;
  logic [NCH-1:0] out_valid;
  logic [NCH-1:0] out_ready;
  logic [PW-1:0]  in_pl  [NCH];
  logic [PW-1:0]  out_pl [NCH];
  logic           run_q;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      run_q <= 1'b0;
    else
      run_q <= 1'b1;
  end

  // --------------------
  // Forward channels
  // --------------------
  assign in_valid[CH_AW] = s.awvalid;
  assign in_pl[CH_AW]    = PW'(s.awaddr);
  assign s.awready       = in_ready[CH_AW];
  assign m.awvalid       = out_valid[CH_AW];
  assign m.awaddr        = out_pl[CH_AW][$bits(addr_t)-1:0];
  assign out_ready[CH_AW] = m.awready;

  assign in_valid[CH_W]  = s.wvalid;
  assign in_pl[CH_W]     = {s.wstrb, s.wdata};
  assign s.wready        = in_ready[CH_W];
  assign m.wvalid        = out_valid[CH_W];
  assign m.wdata         = out_pl[CH_W][$bits(data_t)-1:0];
  assign m.wstrb         = out_pl[CH_W][PW-1:$bits(data_t)];
  assign out_ready[CH_W] = m.wready;

  assign in_valid[CH_AR] = s.arvalid;
  assign in_pl[CH_AR]    = PW'(s.araddr);
  assign s.arready       = in_ready[CH_AR];
  assign m.arvalid       = out_valid[CH_AR];
  assign m.araddr        = out_pl[CH_AR][$bits(addr_t)-1:0];
  assign out_ready[CH_AR] = m.arready;

  // --------------------
  // Response channels
  // --------------------
  assign in_valid[CH_B]  = m.bvalid;
  assign in_pl[CH_B]     = PW'(m.bresp);
  assign m.bready        = in_ready[CH_B];
  assign s.bvalid        = out_valid[CH_B];
  assign s.bresp         = resp_e'(out_pl[CH_B][1:0]);
  assign out_ready[CH_B] = s.bready;

  assign in_valid[CH_R]  = m.rvalid;
  assign in_pl[CH_R]     = PW'({m.rresp, m.rdata});
  assign m.rready        = in_ready[CH_R];
  assign s.rvalid        = out_valid[CH_R];
  assign s.rdata         = out_pl[CH_R][$bits(data_t)-1:0];
  assign s.rresp         = resp_e'(out_pl[CH_R][$bits(data_t)+1:$bits(data_t)]);
  assign out_ready[CH_R] = s.rready;

  for (genvar i = 0; i < NCH; i++)
  begin : g_stage
    logic          full;
    logic [PW-1:0] hold;

    // Accept when empty or draining this cycle
    assign in_ready[i]  = run_q && (!full || out_ready[i]);
    assign out_valid[i] = full;
    assign out_pl[i]    = hold;

    always_ff @(posedge clk)
    begin
      if (!sync_rst_n)
        full <= 1'b0;
      else if (in_valid[i] && in_ready[i])
        full <= 1'b1;
      else if (out_ready[i])
        full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
      if (in_valid[i] && in_ready[i])
        hold <= in_pl[i];
    end

    a_out_stable: assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(out_pl[i])
    );
  end

endmodule

`default_nettype wire

// File: hw/ctl_regs.sv
/*
 * Register target: two read-only IDs and two byte-writable scratch words.
 * One write and one read outstanding at a time; AW and W must arrive together.
 */
`timescale 1ns/1ps
`default_nettype none

module ctl_regs #(
  parameter shell_pkg::data_t ID0 = shell_pkg::DEFAULT_ID0,
  parameter shell_pkg::data_t ID1 = shell_pkg::DEFAULT_ID1
) (
  input  logic  clk,
  input  logic  sync_rst_n,
  axil_if.slave bus
);
  import shell_pkg::*;

  wr_state_e wr_state;
  reg_sel_e  wr_sel;
  reg_sel_e  rd_sel;
  logic      wr_go;
  logic      wr_ok;
  logic      ar_go;
  logic      rd_win;
  logic      bvalid_q;
  logic      rvalid_q;
  resp_e     bresp_q;
  resp_e     rresp_q;
  data_t     rdata_q;
  data_t     rd_word;
  data_t     scratch [2];

  // --------------------
  // Write path
  // --------------------
  assign wr_sel = reg_sel_e'(bus.awaddr[3:2]);
  assign wr_ok  = (bus.awaddr[$bits(addr_t)-1:REG_WINDOW_BITS] == '0) &&
                  (wr_sel == REG_SCRATCH0 || wr_sel == REG_SCRATCH1);
  assign wr_go  = (wr_state == WR_IDLE) && bus.awvalid && bus.wvalid;

  // Address and data only taken as a pair
  assign bus.awready = (wr_state == WR_IDLE) && bus.wvalid;
  assign bus.wready  = (wr_state == WR_IDLE) && bus.awvalid;
  assign bus.bvalid  = bvalid_q;
  assign bus.bresp   = bresp_q;

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      wr_state <= WR_IDLE;
      bvalid_q <= 1'b0;
    end
    else
    begin
      case (wr_state)
        WR_IDLE:
          if (wr_go)
          begin
            wr_state <= WR_RESP;
            bvalid_q <= 1'b1;
          end
        WR_RESP:
          if (bus.bready)
          begin
            wr_state <= WR_IDLE;
            bvalid_q <= 1'b0;
          end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_go)
      bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
  end

  // Byte lanes follow wstrb; slot index is bit 0 of the select
  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
    begin
      scratch[0] <= '0;
      scratch[1] <= '0;
    end
    else if (wr_go && wr_ok)
    begin
      for (int b = 0; b < $bits(strb_t); b++)
        if (bus.wstrb[b])
          scratch[wr_sel[0]][8*b +: 8] <= bus.wdata[8*b +: 8];
    end
  end

  // --------------------
  // Read path
  // --------------------
  assign rd_sel = reg_sel_e'(bus.araddr[3:2]);
  assign rd_win = (bus.araddr[$bits(addr_t)-1:REG_WINDOW_BITS] == '0);
  assign ar_go  = bus.arvalid && !rvalid_q;

  assign bus.arready = ar_go;
  assign bus.rvalid  = rvalid_q;
  assign bus.rdata   = rdata_q;
  assign bus.rresp   = rresp_q;

  always_comb
  begin
    case (rd_sel)
      REG_ID0:      rd_word = ID0;
      REG_ID1:      rd_word = ID1;
      REG_SCRATCH0: rd_word = scratch[0];
      REG_SCRATCH1: rd_word = scratch[1];
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!sync_rst_n)
      rvalid_q <= 1'b0;
    else if (ar_go)
      rvalid_q <= 1'b1;
    else if (bus.rready)
      rvalid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (ar_go)
    begin
      rdata_q <= rd_win ? rd_word : '0;
      rresp_q <= rd_win ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Response only while the write FSM waits on B
  a_bvalid_state: assert property (
    @(posedge clk) disable iff (!sync_rst_n) (wr_state == WR_IDLE) |-> !bus.bvalid
  );

endmodule

`default_nettype wire

// File: hw/shell_top.sv
/*
 * BAR1 custom-logic top: reset and FLR handling, register slice, register block.
 * Access latency is 3 cycles with bready and rready held high.
 */
`timescale 1ns/1ps
`default_nettype none

module shell_top #(
  parameter int               RST_STAGES = 4,
  parameter shell_pkg::data_t ID0        = shell_pkg::DEFAULT_ID0,
  parameter shell_pkg::data_t ID1        = shell_pkg::DEFAULT_ID1
) (
  input  logic              clk,
  input  logic              pipe_rst_n,
  input  logic              flr_assert,
  output logic              flr_done,
  input  logic              awvalid,
  output logic              awready,
  input  shell_pkg::addr_t  awaddr,
  input  logic              wvalid,
  output logic              wready,
  input  shell_pkg::data_t  wdata,
  input  shell_pkg::strb_t  wstrb,
  output logic              bvalid,
  input  logic              bready,
  output shell_pkg::resp_e  bresp,
  input  logic              arvalid,
  output logic              arready,
  input  shell_pkg::addr_t  araddr,
  output logic              rvalid,
  input  logic              rready,
  output shell_pkg::data_t  rdata,
  output shell_pkg::resp_e  rresp
);

  logic sync_rst_n;

  axil_if host_bus ();
  axil_if reg_bus ();

  // --------------------
  // Host ports to host_bus
  // --------------------
  assign host_bus.awvalid = awvalid;
  assign host_bus.awaddr  = awaddr;
  assign awready          = host_bus.awready;
  assign host_bus.wvalid  = wvalid;
  assign host_bus.wdata   = wdata;
  assign host_bus.wstrb   = wstrb;
  assign wready           = host_bus.wready;
  assign bvalid           = host_bus.bvalid;
  assign bresp            = host_bus.bresp;
  assign host_bus.bready  = bready;
  assign host_bus.arvalid = arvalid;
  assign host_bus.araddr  = araddr;
  assign arready          = host_bus.arready;
  assign rvalid           = host_bus.rvalid;
  assign rdata            = host_bus.rdata;
  assign rresp            = host_bus.rresp;
  assign host_bus.rready  = rready;

  rst_flr_ctrl #(.RST_STAGES(RST_STAGES)) u_rst_flr (
    .clk        (clk),
    .pipe_rst_n (pipe_rst_n),
    .flr_assert (flr_assert),
    .sync_rst_n (sync_rst_n),
    .flr_done   (flr_done)
  );

  // Breaks every path between host pins and the register block
  axil_reg_slice u_bar1_slice (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .s          (host_bus.slave),
    .m          (reg_bus.master)
  );

  ctl_regs #(.ID0(ID0), .ID1(ID1)) u_ctl_regs (
    .clk        (clk),
    .sync_rst_n (sync_rst_n),
    .bus        (reg_bus.slave)
  );

endmodule

`default_nettype wire

// File: tb/shell_tb.sv
/*
 * Directed testbench for the BAR1 path, one access in flight at a time.
 * DUT outputs are sampled on the falling edge and inputs change on the rising edge.
 */
`timescale 1ns/1ps
`default_nettype none

module shell_tb;
  import shell_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic  clk;
  logic  pipe_rst_n;
  logic  flr_assert;
  logic  flr_done;
  logic  awvalid;
  logic  awready;
  addr_t awaddr;
  logic  wvalid;
  logic  wready;
  data_t wdata;
  strb_t wstrb;
  logic  bvalid;
  logic  bready;
  resp_e bresp;
  logic  arvalid;
  logic  arready;
  addr_t araddr;
  logic  rvalid;
  logic  rready;
  data_t rdata;
  resp_e rresp;

  int     errors;
  int     checks;
  int     cycles;
  integer seed;
  data_t  model [2];

  shell_top dut0 (
    .clk(clk), .pipe_rst_n(pipe_rst_n), .flr_assert(flr_assert), .flr_done(flr_done),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input string sig, input data_t got, input data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_resp(input string sig, input resp_e got, input resp_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s got %s expected %s", $time, sig, got.name(), exp.name());
    end
  endtask

  task automatic verify_cycles(input string sig, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("error at %0t: %s got %0d expected %0d", $time, sig, got, exp);
    end
  endtask

  // New bytes where the strobe bit is set, old bytes elsewhere
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t strb);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++)
      if (strb[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    return res;
  endfunction

  // --------------------
  // Bus access tasks
  // --------------------
  // stall holds bready low for that many cycles once bvalid shows up
  task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                            input int stall, output resp_e resp, output int lat);
    logic  aw_pend;
    logic  w_pend;
    logic  aw_hit;
    logic  w_hit;
    resp_e held;
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    wvalid  <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    bready  <= (stall == 0);
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    while (aw_pend || w_pend)
    begin
      @(negedge clk);
      aw_hit = aw_pend && awready;
      w_hit  = w_pend && wready;
      @(posedge clk);
      if (aw_hit)
      begin
        awvalid <= 1'b0;
        aw_pend = 1'b0;
      end
      if (w_hit)
      begin
        wvalid <= 1'b0;
        w_pend = 1'b0;
      end
    end
    // Cycles from the accepting cycle to the first one with bvalid
    lat = 1;
    @(negedge clk);
    while (!bvalid)
    begin
      @(negedge clk);
      lat++;
    end
    resp = bresp;
    if (stall > 0)
    begin
      held = bresp;
      repeat (stall)
      begin
        @(negedge clk);
        if (!bvalid)
        begin
          errors++;
          $display("error at %0t: bvalid dropped while bready was low", $time);
        end
        check_resp("bresp", bresp, held);
      end
      @(posedge clk);
      bready <= 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input addr_t addr, input int stall,
                           output data_t data, output resp_e resp, output int lat);
    logic ar_hit;
    ar_hit = 1'b0;
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    rready  <= (stall == 0);
    while (!ar_hit)
    begin
      @(negedge clk);
      ar_hit = arready;
      @(posedge clk);
    end
    arvalid <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (!rvalid)
    begin
      @(negedge clk);
      lat++;
    end
    data = rdata;
    resp = rresp;
    if (stall > 0)
    begin
      repeat (stall)
      begin
        @(negedge clk);
        if (!rvalid)
        begin
          errors++;
          $display("error at %0t: rvalid dropped while rready was low", $time);
        end
        check_data("rdata", rdata, data);
        check_resp("rresp", rresp, resp);
      end
      @(posedge clk);
      rready <= 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic read_ids_after_reset();
    data_t got;
    resp_e resp;
    int    lat;
    axil_read(32'h0, 0, got, resp, lat);
    check_data("rdata id0", got, DEFAULT_ID0);
    check_resp("rresp id0", resp, RESP_OKAY);
    axil_read(32'h4, 0, got, resp, lat);
    check_data("rdata id1", got, DEFAULT_ID1);
    check_resp("rresp id1", resp, RESP_OKAY);
  endtask

  task automatic scratch_strobe_writes();
    data_t word;
    data_t rnd;
    data_t got;
    resp_e resp;
    strb_t strb;
    addr_t addr;
    int    lat;
    for (int pass = 0; pass < 4; pass++)
      for (int slot = 0; slot < 2; slot++)
      begin
        addr = (slot == 0) ? 32'h8 : 32'hC;
        word = $random(seed);
        rnd  = $random(seed);
        // Full strobes first, then fixed and random partial ones
        strb = (pass == 0) ? 4'hF : (pass == 1) ? 4'h5 : (pass == 2) ? 4'hA : rnd[3:0];
        axil_write(addr, word, strb, 0, resp, lat);
        check_resp("bresp scratch", resp, RESP_OKAY);
        model[slot] = merge_bytes(model[slot], word, strb);
        axil_read(addr, 0, got, resp, lat);
        check_data("rdata scratch", got, model[slot]);
        check_resp("rresp scratch", resp, RESP_OKAY);
      end
  endtask

  task automatic error_responses();
    data_t got;
    resp_e resp;
    int    lat;
    axil_write(32'h0, 32'h1234_5678, 4'hF, 0, resp, lat);
    check_resp("bresp id0 write", resp, RESP_SLVERR);
    axil_read(32'h0, 0, got, resp, lat);
    check_data("rdata id0 after write", got, DEFAULT_ID0);
    check_resp("rresp id0 after write", resp, RESP_OKAY);
    axil_write(32'h10, 32'hDEAD_BEEF, 4'hF, 0, resp, lat);
    check_resp("bresp outside window", resp, RESP_SLVERR);
    axil_read(32'h10, 0, got, resp, lat);
    check_data("rdata outside window", got, '0);
    check_resp("rresp outside window", resp, RESP_SLVERR);
    // 0x18 lands on scratch0 if the upper address bits are ignored
    axil_write(32'h18, 32'hCAFE_F00D, 4'hF, 0, resp, lat);
    check_resp("bresp aliased scratch0", resp, RESP_SLVERR);
    axil_read(32'h8, 0, got, resp, lat);
    check_data("rdata scratch0 after bad write", got, model[0]);
  endtask

  task automatic back_pressure_hold();
    data_t word;
    data_t got;
    resp_e resp;
    int    lat;
    word = $random(seed);
    axil_write(32'h8, word, 4'h3, 4, resp, lat);
    check_resp("bresp stalled", resp, RESP_OKAY);
    model[0] = merge_bytes(model[0], word, 4'h3);
    axil_read(32'h8, 5, got, resp, lat);
    check_data("rdata stalled", got, model[0]);
    check_resp("rresp stalled", resp, RESP_OKAY);
  endtask

  task automatic unstalled_latency();
    data_t word;
    data_t got;
    resp_e resp;
    int    lat;
    word = $random(seed);
    axil_write(32'hC, word, 4'hF, 0, resp, lat);
    verify_cycles("write latency", lat, 3);
    model[1] = word;
    axil_read(32'hC, 0, got, resp, lat);
    verify_cycles("read latency", lat, 3);
    check_data("rdata latency", got, model[1]);
  endtask

  task automatic flr_pulse_and_keep();
    logic  prev;
    logic  now_done;
    int    first;
    data_t got;
    resp_e resp;
    int    lat;
    prev  = 1'b0;
    first = -1;
    @(posedge clk);
    flr_assert <= 1'b1;
    // Cycle 0 is the one in which flr_assert rises
    for (int i = 0; i < 8; i++)
    begin
      @(negedge clk);
      now_done = flr_done;
      if (now_done && prev)
      begin
        errors++;
        $display("error at %0t: flr_done high on two cycles in a row", $time);
      end
      if (now_done && first < 0)
        first = i;
      prev = now_done;
    end
    @(posedge clk);
    flr_assert <= 1'b0;
    verify_cycles("flr_done delay", first, 2);
    repeat (3) @(posedge clk);
    axil_read(32'h8, 0, got, resp, lat);
    check_data("rdata scratch0 after flr", got, model[0]);
    axil_read(32'hC, 0, got, resp, lat);
    check_data("rdata scratch1 after flr", got, model[1]);
  endtask

  // --------------------
  // Sequence and end of run
  // --------------------
  initial
  begin
    errors = 0;
    checks = 0;
    seed   = 44;
    model[0] = '0;
    model[1] = '0;
    pipe_rst_n <= 1'b0;
    flr_assert <= 1'b0;
    awvalid    <= 1'b0;
    awaddr     <= '0;
    wvalid     <= 1'b0;
    wdata      <= '0;
    wstrb      <= '0;
    bready     <= 1'b0;
    arvalid    <= 1'b0;
    araddr     <= '0;
    rready     <= 1'b0;
    repeat (5) @(posedge clk);
    pipe_rst_n <= 1'b1;
    read_ids_after_reset();
    scratch_strobe_writes();
    error_responses();
    back_pressure_hold();
    unstalled_latency();
    flr_pulse_and_keep();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // Whole sequence runs a few hundred cycles
  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("error: run stopped after %0d cycles without finishing", cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
hw/shell_pkg.sv
hw/axil_if.sv
hw/rst_flr_ctrl.sv
hw/axil_reg_slice.sv
hw/ctl_regs.sv
hw/shell_top.sv
tb/shell_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = shell_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
